// File: source/husky_capture_cfg.svh
`ifndef HUSKY_CAPTURE_CFG_SVH
`define HUSKY_CAPTURE_CFG_SVH

// sample memory size, in adc words
`define CAP_BUF_DEPTH 256

// log2 of the depth
`define CAP_ADDR_W 8

// sample count setting, wide enough to hold the full depth
`define CAP_CNT_W 9

// downsample setting, keeps every (d+1)-th word
`define CAP_DS_W 4

`endif

// File: source/husky_capture_pkg.sv
package husky_capture_pkg;

   // adc word width, data arrives already deserialized
   localparam int ADC_W = 12;

   // one conversion result, unsigned
   typedef logic [ADC_W-1:0] adc_sample_t;

   // capture sequencing
   typedef enum logic [1:0] {
      CAP_IDLE      = 2'd0, // after reset, nothing stored
      CAP_ARMED     = 2'd1, // waiting for trigger edge
      CAP_CAPTURING = 2'd2, // storing words
      CAP_DONE      = 2'd3  // buffer full, host may read
   } cap_state_e;

endpackage

// File: source/capture_ctrl_if.sv
`timescale 1ns/1ps

// control path between the capture fsm and the sample timer
interface capture_ctrl_if;

   logic cnt_clear; // reload divider, zero count
   logic cnt_run;   // timer only moves while high
   logic keep_tick; // store this cycle's word
   logic last_tick; // final word of the capture, only with keep_tick

   // fsm side
   modport ctrl_mp (
      output cnt_clear,
      output cnt_run,
      input  keep_tick,
      input  last_tick
   );

   // timer side
   modport timer_mp (
      input  cnt_clear,
      input  cnt_run,
      output keep_tick,
      output last_tick
   );

endinterface

// File: source/adc_front.sv
`timescale 1ns/1ps

// input stage: aligns the adc word with trigger edge detection
module adc_front import husky_capture_pkg::*; (
   input  logic        ADC_clk_fb,
   input  logic        rst_n_i,
   input  adc_sample_t adc_data_i,
   input  logic        trig_i,
   output adc_sample_t sample_o,
   output logic        trig_rise_o
);

   adc_sample_t sample_q; // word sampled at the same edge as trig_q
   logic        trig_q;   // trigger as sampled this edge
   logic        trig_qq;  // trigger one edge earlier

   // data path, one cycle of latency
   always_ff @(posedge ADC_clk_fb) begin
      sample_q <= adc_data_i;
   end

   // trigger level history
   always_ff @(posedge ADC_clk_fb) begin
      if (!rst_n_i) begin
         // load the live level on both stages
         // so a trigger held high through reset is not an edge
         trig_q  <= trig_i;
         trig_qq <= trig_i;
      end else begin
         trig_q  <= trig_i;
         trig_qq <= trig_q;
      end
   end

   // high for one cycle after the edge that first sees trig high
   // sample_o in that same cycle is the word taken at that edge
   assign trig_rise_o = trig_q & ~trig_qq;

   assign sample_o = sample_q;

endmodule

// File: source/capture_fsm.sv
`timescale 1ns/1ps

// idle / armed / capturing / done sequencing
module capture_fsm import husky_capture_pkg::*; (
   input  logic            ADC_clk_fb,
   input  logic            rst_n_i,
   input  logic            arm_i,
   input  logic            trig_rise_i,
   capture_ctrl_if.ctrl_mp ctrl,
   output logic            buf_wr_o,
   output logic            buf_clear_o,
   output logic            armed_o,
   output logic            capturing_o,
   output logic            done_o
);

   cap_state_e state_q;
   cap_state_e state_d;
   logic       arm_ok;   // arm pulse that counts
   logic       trig_ok;  // trigger edge while armed
   logic       last_wr;  // final word goes in this cycle

   // arm only honored when no capture is in flight
   assign arm_ok  = arm_i && (state_q == CAP_IDLE || state_q == CAP_DONE);
   assign trig_ok = trig_rise_i && (state_q == CAP_ARMED);
   assign last_wr = ctrl.keep_tick && ctrl.last_tick;

   // clears are single cycle, same cycle as the accepted arm
   assign ctrl.cnt_clear = arm_ok;
   assign buf_clear_o    = arm_ok;

   // run already on the trigger cycle
   // so tick zero lands on the trigger word
   assign ctrl.cnt_run = trig_ok || (state_q == CAP_CAPTURING);

   // keep_tick can only fire while running
   assign buf_wr_o = ctrl.keep_tick;

   always_comb begin
      state_d = state_q; // hold by default
      case (state_q)
         CAP_IDLE, CAP_DONE: begin
            if (arm_ok) begin
               state_d = CAP_ARMED;
            end
         end
         CAP_ARMED: begin
            // a single word capture finishes on the trigger cycle
            if (trig_ok) begin
               state_d = last_wr ? CAP_DONE : CAP_CAPTURING;
            end
         end
         CAP_CAPTURING: begin
            if (last_wr) begin
               state_d = CAP_DONE; // drops cnt_run next cycle
            end
         end
         default: begin
            state_d = CAP_IDLE;
         end
      endcase
   end

   always_ff @(posedge ADC_clk_fb) begin
      if (!rst_n_i) begin
         state_q     <= CAP_IDLE;
         armed_o     <= 1'b0;
         capturing_o <= 1'b0;
         done_o      <= 1'b0;
      end else begin
         state_q     <= state_d;
         // status lags the state by one edge
         armed_o     <= (state_q == CAP_ARMED);
         capturing_o <= (state_q == CAP_CAPTURING);
         done_o      <= (state_q == CAP_DONE);
      end
   end

endmodule

// File: source/sample_timer.sv
`timescale 1ns/1ps
`include "husky_capture_cfg.svh"

// downsample divider plus count of stored words
module sample_timer import husky_capture_pkg::*; (
   input  logic                  ADC_clk_fb,
   input  logic                  rst_n_i,
   input  logic [`CAP_CNT_W-1:0] num_samples_i,
   input  logic [`CAP_DS_W-1:0]  downsample_i,
   capture_ctrl_if.timer_mp      tmr
);

   localparam logic [`CAP_CNT_W-1:0] DEPTH_C = `CAP_BUF_DEPTH;

   logic [`CAP_DS_W-1:0]  div_q;    // 0..downsample_i
   logic [`CAP_CNT_W-1:0] cnt_q;    // words kept so far
   logic [`CAP_CNT_W-1:0] last_idx; // index of final word

   // effective n is num clipped to 1..depth
   always_comb begin
      if (num_samples_i == '0) begin
         last_idx = '0;
      end else if (num_samples_i > DEPTH_C) begin
         last_idx = DEPTH_C - 1'b1;
      end else begin
         last_idx = num_samples_i - 1'b1;
      end
   end

   // combinational so the first tick comes with cnt_run
   assign tmr.keep_tick = tmr.cnt_run && (div_q == '0);
   assign tmr.last_tick = tmr.keep_tick && (cnt_q == last_idx);

   always_ff @(posedge ADC_clk_fb) begin
      if (!rst_n_i || tmr.cnt_clear) begin
         div_q <= '0;
         cnt_q <= '0;
      end else if (tmr.cnt_run) begin
         if (div_q == downsample_i) begin
            div_q <= '0; // wrap, next word is kept
         end else begin
            div_q <= div_q + 1'b1;
         end
         if (tmr.keep_tick) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

endmodule

// File: source/sample_buffer.sv
`timescale 1ns/1ps
`include "husky_capture_cfg.svh"

// capture memory, filled in order, read back in the same order
module sample_buffer import husky_capture_pkg::*; (
   input  logic        ADC_clk_fb,
   input  logic        rst_n_i,
   input  logic        clear_i,
   input  logic        wr_i,
   input  adc_sample_t wr_data_i,
   input  logic        rd_i,
   output adc_sample_t rd_data_o,
   output logic        rd_valid_o
);

   localparam logic [`CAP_ADDR_W:0] DEPTH_C = `CAP_BUF_DEPTH;

   adc_sample_t              mem [`CAP_BUF_DEPTH]; // inferred ram
   logic [`CAP_ADDR_W-1:0]   wr_ptr_q;
   logic [`CAP_ADDR_W:0]     fill_q;   // words held, 0..depth
   logic [`CAP_ADDR_W:0]     rd_ptr_q; // one bit wider, reaches depth
   adc_sample_t              rd_data_q;
   logic                     rd_valid_q;
   logic                     wr_ok;
   logic                     rd_ok;

   // never write past full, wr_ptr would wrap
   assign wr_ok = wr_i && (fill_q != DEPTH_C);
   // clear wins over a read in the same cycle
   assign rd_ok = rd_i && !clear_i && (rd_ptr_q < fill_q);

   always_ff @(posedge ADC_clk_fb) begin
      if (wr_ok) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

   // pointers and fill level
   always_ff @(posedge ADC_clk_fb) begin
      if (!rst_n_i || clear_i) begin
         wr_ptr_q <= '0;
         fill_q   <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
            fill_q   <= fill_q + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // registered readout
   always_ff @(posedge ADC_clk_fb) begin
      if (rd_ok) begin
         rd_data_q <= mem[rd_ptr_q[`CAP_ADDR_W-1:0]];
      end
   end

   always_ff @(posedge ADC_clk_fb) begin
      if (!rst_n_i) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= rd_ok; // low for reads past the end
      end
   end

   assign rd_data_o  = rd_data_q;
   assign rd_valid_o = rd_valid_q;

endmodule

// File: source/husky_capture_top.sv
`timescale 1ns/1ps
`include "husky_capture_cfg.svh"

// adc capture subsystem, everything on the adc feedback clock
module husky_capture_top import husky_capture_pkg::*; (
   input  logic                  ADC_clk_fb,
   input  logic                  rst_n_i,
   input  logic [ADC_W-1:0]      adc_data_i,
   input  logic                  trig_i,
   input  logic                  arm_i,
   input  logic [`CAP_CNT_W-1:0] num_samples_i, // 0 means 1, clipped to depth
   input  logic [`CAP_DS_W-1:0]  downsample_i,  // keep every (d+1)-th word
   input  logic                  rd_en_i,
   output logic [ADC_W-1:0]      rd_data_o,
   output logic                  rd_valid_o,
   output logic                  armed_o,
   output logic                  capturing_o,
   output logic                  done_o
);

   adc_sample_t sample;    // registered adc word
   adc_sample_t rd_word;
   logic        trig_rise; // one cycle per trigger edge
   logic        buf_wr;
   logic        buf_clear;
   logic        buf_rd;

   capture_ctrl_if ctrl_if ();

   // host reads only count once done
   assign buf_rd = rd_en_i & done_o;

   adc_front u_adc_front (
      .ADC_clk_fb  (ADC_clk_fb),
      .rst_n_i     (rst_n_i),
      .adc_data_i  (adc_data_i),
      .trig_i      (trig_i),
      .sample_o    (sample),
      .trig_rise_o (trig_rise)
   );

   capture_fsm u_capture_fsm (
      .ADC_clk_fb  (ADC_clk_fb),
      .rst_n_i     (rst_n_i),
      .arm_i       (arm_i),
      .trig_rise_i (trig_rise),
      .ctrl        (ctrl_if.ctrl_mp),
      .buf_wr_o    (buf_wr),
      .buf_clear_o (buf_clear),
      .armed_o     (armed_o),
      .capturing_o (capturing_o),
      .done_o      (done_o)
   );

   sample_timer u_sample_timer (
      .ADC_clk_fb    (ADC_clk_fb),
      .rst_n_i       (rst_n_i),
      .num_samples_i (num_samples_i),
      .downsample_i  (downsample_i),
      .tmr           (ctrl_if.timer_mp)
   );

   sample_buffer u_sample_buffer (
      .ADC_clk_fb (ADC_clk_fb),
      .rst_n_i    (rst_n_i),
      .clear_i    (buf_clear),
      .wr_i       (buf_wr),
      .wr_data_i  (sample),
      .rd_i       (buf_rd),
      .rd_data_o  (rd_word),
      .rd_valid_o (rd_valid_o)
   );

   assign rd_data_o = rd_word;

endmodule

// File: dv/husky_capture_tb.sv
`timescale 1ns/1ps
`include "husky_capture_cfg.svh"

module husky_capture_tb import husky_capture_pkg::*; ();

   localparam int          CLK_PERIOD  = 8;
   localparam int          DEPTH       = `CAP_BUF_DEPTH;
   localparam int          DS_SPAN     = 1 << `CAP_DS_W;
   localparam int          TEST_CYCLES = DEPTH*16 + 2*DEPTH + 100; // per test budget
   localparam int          NUM_TESTS   = 16;
   localparam int          RAND_ROUNDS = 6;
   localparam int unsigned SEED        = 32'h759f_db28;

   logic                  ADC_clk_fb = 1'b0;
   logic                  rst_n_i;
   adc_sample_t           adc_data_i;
   logic                  trig_i;
   logic                  arm_i;
   logic [`CAP_CNT_W-1:0] num_samples_i;
   logic [`CAP_DS_W-1:0]  downsample_i;
   logic                  rd_en_i;
   adc_sample_t           rd_data_o;
   logic                  rd_valid_o;
   logic                  armed_o;
   logic                  capturing_o;
   logic                  done_o;

   int          cyc = 0;          // number of the next edge
   adc_sample_t sample_log [int]; // adc word seen by the dut, per edge
   int          trig_edge;        // edge e of the current capture
   int          errors = 0;
   int          checks = 0;

   husky_capture_top dut_i (
      .ADC_clk_fb    (ADC_clk_fb),
      .rst_n_i       (rst_n_i),
      .adc_data_i    (adc_data_i),
      .trig_i        (trig_i),
      .arm_i         (arm_i),
      .num_samples_i (num_samples_i),
      .downsample_i  (downsample_i),
      .rd_en_i       (rd_en_i),
      .rd_data_o     (rd_data_o),
      .rd_valid_o    (rd_valid_o),
      .armed_o       (armed_o),
      .capturing_o   (capturing_o),
      .done_o        (done_o)
   );

   always #(CLK_PERIOD/2) ADC_clk_fb = ~ADC_clk_fb;

   // fresh adc word every cycle, the old one is what this edge samples
   always @(posedge ADC_clk_fb) begin
      sample_log[cyc] = adc_data_i;
      adc_data_i      <= adc_sample_t'($urandom);
      cyc             <= cyc + 1;
   end

   task automatic compare_value(input string name, input string what, input int exp,
                                input int act);
      checks++;
      if (exp != act) begin
         errors++;
         $display("ERR %s: %s expected 0x%0h actual 0x%0h", name, what, exp, act);
      end
   endtask

   // n of 0 stores one word, anything above depth stores depth words
   function automatic int effective_n(input int n);
      if (n == 0) begin
         return 1;
      end
      if (n > DEPTH) begin
         return DEPTH;
      end
      return n;
   endfunction

   task automatic arm_capture(input string name);
      @(posedge ADC_clk_fb);
      arm_i <= 1'b1;
      @(posedge ADC_clk_fb);
      arm_i <= 1'b0;
      @(posedge ADC_clk_fb); // status is a registered decode
      @(negedge ADC_clk_fb);
      compare_value(name, "armed_o after arm", 1, int'(armed_o));
      compare_value(name, "done_o after arm", 0, int'(done_o));
   endtask

   // trigger pulse, then follow capturing_o and done_o edge by edge
   task automatic trigger_capture(input string name, input int n, input int ds,
                                  input bit arm_mid);
      int last_edge;
      int done_edge;
      int delay;
      bit exp_cap;
      delay = $urandom % 8;
      repeat (delay) @(posedge ADC_clk_fb);
      @(posedge ADC_clk_fb);
      trig_i    <= 1'b1;
      trig_edge = cyc + 1; // first edge that sees trig high
      done_edge = trig_edge + (effective_n(n) - 1)*(ds + 1) + 2;
      @(posedge ADC_clk_fb);
      trig_i <= 1'b0;
      @(posedge ADC_clk_fb);
      arm_i   <= arm_mid;    // sampled at e+2, capture in flight
      rd_en_i <= (effective_n(n) > 1); // read while capturing, must be ignored
      @(posedge ADC_clk_fb);
      arm_i   <= 1'b0;
      rd_en_i <= 1'b0;
      forever begin
         @(negedge ADC_clk_fb);
         last_edge = cyc - 1;
         exp_cap = (effective_n(n) > 1) && (last_edge >= trig_edge + 2) &&
                   (last_edge < done_edge);
         compare_value(name, "capturing_o", int'(exp_cap), int'(capturing_o));
         compare_value(name, "rd_valid_o before done", 0, int'(rd_valid_o));
         if (done_o) begin
            break;
         end
         if (last_edge > done_edge) begin
            errors++;
            $display("%s: done_o did not rise by edge %0d", name, done_edge);
            break;
         end
      end
      compare_value(name, "done_o rise edge", done_edge, last_edge);
   endtask

   // streamed reads, one extra past the end
   task automatic read_back(input string name, input int n, input int ds);
      int n_eff;
      int k;
      n_eff = effective_n(n);
      @(posedge ADC_clk_fb);
      rd_en_i <= 1'b1;
      for (k = 0; k <= n_eff; k++) begin
         @(posedge ADC_clk_fb);
         if (k == n_eff) begin
            rd_en_i <= 1'b0;
         end
         @(negedge ADC_clk_fb);
         if (k < n_eff) begin
            compare_value(name, "rd_valid_o", 1, int'(rd_valid_o));
            compare_value(name, $sformatf("word %0d", k),
                          int'(sample_log[trig_edge + k*(ds + 1)]), int'(rd_data_o));
         end else begin
            compare_value(name, "rd_valid_o past end", 0, int'(rd_valid_o));
         end
      end
   endtask

   task automatic run_capture(input string name, input int n, input int ds,
                              input bit arm_mid);
      @(posedge ADC_clk_fb);
      num_samples_i <= `CAP_CNT_W'(n);
      downsample_i  <= `CAP_DS_W'(ds);
      arm_capture(name);
      trigger_capture(name, n, ds, arm_mid);
      read_back(name, n, ds);
   endtask

   // trigger outside armed, nothing may start
   task automatic stray_trigger(input string name, input int exp_done);
      @(posedge ADC_clk_fb);
      trig_i <= 1'b1;
      @(posedge ADC_clk_fb);
      trig_i <= 1'b0;
      repeat (4) @(posedge ADC_clk_fb);
      @(negedge ADC_clk_fb);
      compare_value(name, "armed_o", 0, int'(armed_o));
      compare_value(name, "capturing_o", 0, int'(capturing_o));
      compare_value(name, "done_o", exp_done, int'(done_o));
   endtask

   initial begin
      #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      int i;
      void'($urandom(SEED));
      rst_n_i       = 1'b0;
      adc_data_i    = '0;
      trig_i        = 1'b0;
      arm_i         = 1'b0;
      num_samples_i = '0;
      downsample_i  = '0;
      rd_en_i       = 1'b0;
      repeat (2) @(posedge ADC_clk_fb);
      rst_n_i <= 1'b1;
      @(negedge ADC_clk_fb);
      compare_value("reset", "armed_o", 0, int'(armed_o));
      compare_value("reset", "capturing_o", 0, int'(capturing_o));
      compare_value("reset", "done_o", 0, int'(done_o));
      compare_value("reset", "rd_valid_o", 0, int'(rd_valid_o));
      @(posedge ADC_clk_fb);
      rd_en_i <= 1'b1; // read while idle
      @(posedge ADC_clk_fb);
      rd_en_i <= 1'b0;
      @(negedge ADC_clk_fb);
      compare_value("reset", "rd_valid_o idle read", 0, int'(rd_valid_o));
      stray_trigger("trig_idle", 0);
      for (i = 0; i < RAND_ROUNDS; i++) begin
         run_capture($sformatf("rand_%0d", i), 1 + $urandom % DEPTH, $urandom % DS_SPAN, 1'b0);
      end
      run_capture("n_zero", 0, $urandom % DS_SPAN, 1'b0);
      run_capture("n_over", DEPTH + 44, 0, 1'b0); // clipped to depth
      run_capture("n_full", DEPTH, 1, 1'b0);
      stray_trigger("trig_done", 1);
      // trigger already high when armed, no edge
      @(posedge ADC_clk_fb);
      trig_i        <= 1'b1;
      num_samples_i <= `CAP_CNT_W'(12);
      downsample_i  <= `CAP_DS_W'(2);
      arm_capture("trig_held");
      repeat (6) @(posedge ADC_clk_fb);
      @(negedge ADC_clk_fb);
      compare_value("trig_held", "armed_o", 1, int'(armed_o));
      compare_value("trig_held", "capturing_o", 0, int'(capturing_o));
      @(posedge ADC_clk_fb);
      trig_i <= 1'b0;
      trigger_capture("trig_held", 12, 2, 1'b0);
      read_back("trig_held", 12, 2);
      run_capture("arm_mid", 20, 3, 1'b1);
      // smaller capture after a bigger one, old words must be gone
      run_capture("rearm_big", 40, 0, 1'b0);
      run_capture("rearm_small", 5, 2, 1'b0);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: husky_capture.f
+incdir+source
source/husky_capture_pkg.sv
source/capture_ctrl_if.sv
source/adc_front.sv
source/capture_fsm.sv
source/sample_timer.sv
source/sample_buffer.sv
source/husky_capture_top.sv
dv/husky_capture_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the capture testbench with verilator

ROOT=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT" || exit 1

TOP=husky_capture_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
   -f husky_capture.f \
   --top-module "$TOP" \
   --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see $LOG"
   exit 1
fi
